// File: Makefile
# Verilator build for the four lane receive subsystem
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP_TB    ?= ilkn_rx_tb
TOP_RTL   ?= ilkn_rx_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
SIM_BIN   ?= sim_$(TOP_TB)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP_RTL)

# the binary exits non-zero when the testbench stops with $$fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: ilkn_burst_parser.sv
////////////////////////////////////////////////////////////////////////////
// burst parser, walks each aligned row in lane order
// tracks SOP / EOP, captures the calendar and flags protocol errors,
// the row goes out one cycle after it arrives
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ilkn_rx_params.svh"

module ilkn_burst_parser (
	input  logic                                              common_clk,
	input  logic                                              arst_n,
	ilkn_row_if.sink                                          row,
	output ilkn_burst_pkg::out_word_t [`ILKN_NUM_LANES-1:0]   outwords,
	output logic                                              outwords_valid,
	output ilkn_burst_pkg::calendar_t                         calendar,
	output logic                                              burst_err
);

	ilkn_burst_pkg::parser_state_t state;
	ilkn_burst_pkg::parser_state_t state_next;
	ilkn_burst_pkg::calendar_t calendar_next;
	logic err_next;
	logic sop;
	logic eop;

	//////////////////////////////////////////////////////////////////////////
	// scan the row word by word, lane 0 first
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_next = state;
		calendar_next = calendar;
		err_next = 1'b0;
		sop = 1'b0;
		eop = 1'b0;
		for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
			if (row.ctl[i] && row.words[i][ilkn_burst_pkg::BCW_BIT]) begin
				sop = row.words[i][ilkn_burst_pkg::SOP_BIT];
				eop = row.words[i][ilkn_burst_pkg::EOP_BIT];
				// later lanes overwrite, so the highest lane wins
				calendar_next = row.words[i][ilkn_burst_pkg::CAL_LSB +: `ILKN_CAL_W];
				if (sop) begin
					// SOP inside an open burst is an error
					if (state_next == ilkn_burst_pkg::IN_BURST) begin
						err_next = 1'b1;
					end
					// SOP and EOP together make a one word burst
					state_next = eop ? ilkn_burst_pkg::OUTSIDE : ilkn_burst_pkg::IN_BURST;
				end else if (eop) begin
					if (state_next == ilkn_burst_pkg::OUTSIDE) begin
						err_next = 1'b1;
					end
					state_next = ilkn_burst_pkg::OUTSIDE;
				end
			end else if (!row.ctl[i]) begin
				// data with no burst open
				if (state_next == ilkn_burst_pkg::OUTSIDE) begin
					err_next = 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// burst state, calendar and status flags
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge common_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ilkn_burst_pkg::OUTSIDE;
			calendar <= '1;
			outwords_valid <= 1'b0;
			burst_err <= 1'b0;
		end else begin
			outwords_valid <= row.valid;
			burst_err <= row.valid && err_next;
			if (!row.locked) begin
				// any burst in flight is abandoned when lock goes
				state <= ilkn_burst_pkg::OUTSIDE;
			end else if (row.valid) begin
				state <= state_next;
				calendar <= calendar_next;
			end
		end
	end

	// output words keep the control flag so control rows stay recognisable
	always_ff @(posedge common_clk) begin
		if (row.valid) begin
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				outwords[i] <= {row.ctl[i], row.words[i]};
			end
		end
	end

endmodule

`default_nettype wire

// File: ilkn_burst_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types for the burst side of the receiver
// output words, calendar and the burst control word layout
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "ilkn_rx_params.svh"

package ilkn_burst_pkg;

	// output word is the lane word with the sync marker removed
	typedef logic [`ILKN_LANE_W-2:0] out_word_t;

	// one page of flow control status, one bit per calendar entry
	typedef logic [`ILKN_CAL_W-1:0] calendar_t;

	// channel number carried by a burst control word
	typedef logic [7:0] channel_t;

	//////////////////////////////////////////////////////////////////////////
	// burst control word layout, control flag set on the lane
	//   [63]    set for burst / idle words, clear for framing words
	//   [61]    SOP, first word of a burst follows
	//   [60]    EOP, previous burst ends here
	//   [55:40] flow control calendar
	//   [39:32] channel
	// a burst control word with neither SOP nor EOP is an idle word
	//////////////////////////////////////////////////////////////////////////
	localparam int BCW_BIT = 63;
	localparam int SOP_BIT = 61;
	localparam int EOP_BIT = 60;
	localparam int CAL_LSB = 40;
	localparam int CHAN_LSB = 32;

	// between bursts, or inside an open burst
	typedef enum logic {
		OUTSIDE,
		IN_BURST
	} parser_state_t;

endpackage

`default_nettype wire

// File: ilkn_lane_deskew.sv
////////////////////////////////////////////////////////////////////////////
// lane deskew, lines the four lanes up on their sync markers
// each lane has a small FIFO that soaks up its skew; rows come out one
// cycle after a pop, with framing rows removed
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ilkn_rx_params.svh"

module ilkn_lane_deskew (
	input  logic                                              common_clk,
	input  logic                                              arst_n,
	input  ilkn_lane_pkg::lane_word_t [`ILKN_NUM_LANES-1:0]   lane_words,
	input  logic [`ILKN_NUM_LANES-1:0]                        lane_valid,
	ilkn_row_if.source                                        row
);

	localparam int PTR_W = $clog2(`ILKN_SKEW_DEPTH);

	// framing detection looks at one lane only, aligned lanes agree
	localparam ilkn_lane_pkg::lane_idx_t REF_LANE = '0;

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [PTR_W:0]   cnt_t;

	ilkn_lane_pkg::deskew_state_t state;

	// skew FIFO storage and pointers, one set per lane
	ilkn_lane_pkg::lane_word_t mem [`ILKN_NUM_LANES][`ILKN_SKEW_DEPTH];
	ptr_t wr_ptr [`ILKN_NUM_LANES];
	ptr_t rd_ptr [`ILKN_NUM_LANES];
	cnt_t cnt [`ILKN_NUM_LANES];

	ilkn_lane_pkg::lane_word_t [`ILKN_NUM_LANES-1:0] heads;
	logic [`ILKN_NUM_LANES-1:0] head_sync;
	logic [`ILKN_NUM_LANES-1:0] empty;
	logic [`ILKN_NUM_LANES-1:0] full;
	logic [`ILKN_NUM_LANES-1:0] wr_en;
	logic [`ILKN_NUM_LANES-1:0] overrun;

	logic pop;
	logic sync_mismatch;
	logic framing_row;
	logic flush;

	//////////////////////////////////////////////////////////////////////////
	// FIFO status and write decisions
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
			heads[i] = mem[i][rd_ptr[i]];
			head_sync[i] = heads[i][ilkn_lane_pkg::SYNC_BIT];
			empty[i] = (cnt[i] == '0);
			full[i] = (cnt[i] == cnt_t'(`ILKN_SKEW_DEPTH));
			// while hunting a lane throws words away until its first sync word,
			// a non-empty FIFO means that word has already been taken
			wr_en[i] = lane_valid[i] &&
				(state == ilkn_lane_pkg::LOCKED || !empty[i] ||
				lane_words[i][ilkn_lane_pkg::SYNC_BIT]);
		end
	end

	// one word leaves every lane together, only once aligned
	assign pop = (state == ilkn_lane_pkg::LOCKED) && !(|empty);

	// a full FIFO can still take a word in a cycle where it is also popped
	assign overrun = wr_en & full & {`ILKN_NUM_LANES{!pop}};

	// every sync row after lock must line up across all lanes
	assign sync_mismatch = (|head_sync) && !(&head_sync);

	// framing layer words have the control flag set and bit 63 clear
	assign framing_row = heads[REF_LANE][ilkn_lane_pkg::CTL_BIT] &&
		!heads[REF_LANE][ilkn_burst_pkg::BCW_BIT];

	assign flush = (|overrun) || (pop && sync_mismatch);

	//////////////////////////////////////////////////////////////////////////
	// lock FSM
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge common_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ilkn_lane_pkg::HUNT;
		end else if (flush) begin
			state <= ilkn_lane_pkg::HUNT;
		end else if (state == ilkn_lane_pkg::HUNT && (&head_sync) && !(|empty)) begin
			// all heads sit on a sync word, so the lanes are aligned
			state <= ilkn_lane_pkg::LOCKED;
		end
	end

	assign row.locked = (state == ilkn_lane_pkg::LOCKED);

	//////////////////////////////////////////////////////////////////////////
	// FIFO pointers and occupancy
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge common_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				if (flush) begin
					// losing lock empties every lane so hunting starts clean
					wr_ptr[i] <= '0;
					rd_ptr[i] <= '0;
					cnt[i] <= '0;
				end else begin
					if (wr_en[i]) begin
						wr_ptr[i] <= wr_ptr[i] + ptr_t'(1);
					end
					if (pop) begin
						rd_ptr[i] <= rd_ptr[i] + ptr_t'(1);
					end
					if (wr_en[i] && !pop) begin
						cnt[i] <= cnt[i] + cnt_t'(1);
					end else if (!wr_en[i] && pop) begin
						cnt[i] <= cnt[i] - cnt_t'(1);
					end
				end
			end
		end
	end

	// storage, a write during a flush lands in a slot that is now free
	always_ff @(posedge common_clk) begin
		for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
			if (wr_en[i]) begin
				mem[i][wr_ptr[i]] <= lane_words[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// output row register
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge common_clk or negedge arst_n) begin
		if (!arst_n) begin
			row.valid <= 1'b0;
		end else begin
			row.valid <= pop && !sync_mismatch && !framing_row;
		end
	end

	// sync markers are dropped here, the parser never needs them
	always_ff @(posedge common_clk) begin
		if (pop) begin
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				row.words[i] <= heads[i][63:0];
				row.ctl[i] <= heads[i][ilkn_lane_pkg::CTL_BIT];
			end
		end
	end

endmodule

`default_nettype wire

// File: ilkn_lane_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types for the lane side of the receiver
// lane words as they leave the lane RX block, and the deskew FSM states
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "ilkn_rx_params.svh"

package ilkn_lane_pkg;

	// one lane word, [65] sync marker, [64] control flag, [63:0] payload
	typedef logic [`ILKN_LANE_W-1:0] lane_word_t;

	// payload part of a lane word
	typedef logic [63:0] payload_t;

	// selects one of the lanes
	typedef logic [$clog2(`ILKN_NUM_LANES)-1:0] lane_idx_t;

	// bit positions inside a lane word
	localparam int SYNC_BIT = `ILKN_LANE_W - 1;
	localparam int CTL_BIT = `ILKN_LANE_W - 2;

	// hunting for a common sync row, or aligned and streaming
	typedef enum logic {
		HUNT,
		LOCKED
	} deskew_state_t;

endpackage

`default_nettype wire

// File: ilkn_row_if.sv
////////////////////////////////////////////////////////////////////////////
// one aligned row passed from lane deskew to the burst parser
// deskew drives it through source, the parser reads it through sink
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ilkn_rx_params.svh"

interface ilkn_row_if;

	// payloads in lane order, lane 0 holds the earliest word of the row
	ilkn_lane_pkg::payload_t [`ILKN_NUM_LANES-1:0] words;

	// control flag of each lane word
	logic [`ILKN_NUM_LANES-1:0] ctl;

	// row carries data or burst control, framing rows never raise this
	logic valid;

	// lanes are aligned, follows the deskew FSM directly
	logic locked;

	modport source (
		output words,
		output ctl,
		output valid,
		output locked
	);

	modport sink (
		input words,
		input ctl,
		input valid,
		input locked
	);

endinterface

`default_nettype wire

// File: ilkn_rx_params.svh
////////////////////////////////////////////////////////////////////////////
// sizing macros for the four lane receive path
// include this wherever the lane count or word widths are needed
////////////////////////////////////////////////////////////////////////////
`ifndef ILKN_RX_PARAMS_SVH
`define ILKN_RX_PARAMS_SVH

// number of lanes striped together into one row
`define ILKN_NUM_LANES 4

// lane word is {sync marker, control flag, 64 payload bits}
`define ILKN_LANE_W 66

// words of skew each lane can absorb before lock is lost
`define ILKN_SKEW_DEPTH 8

// single page flow control calendar
`define ILKN_CAL_W 16

`endif

// File: ilkn_rx_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the four lane receive top
// builds skewed lane streams from rows, predicts the output rows and
// checks every row the DUT produces against that prediction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ilkn_rx_params.svh"

module ilkn_rx_tb;

	typedef ilkn_lane_pkg::lane_word_t [`ILKN_NUM_LANES-1:0] lane_row_t;
	typedef ilkn_burst_pkg::out_word_t [`ILKN_NUM_LANES-1:0] out_row_t;
	typedef logic [$bits(out_row_t)-1:0] wide_t;

	logic common_clk;
	logic arst_n;
	lane_row_t lane_words;
	logic [`ILKN_NUM_LANES-1:0] lane_valid;
	logic locked;
	out_row_t outwords;
	logic outwords_valid;
	ilkn_burst_pkg::calendar_t calendar;
	logic burst_err;

	// rows still to be sent, and the rows the DUT should produce from them
	lane_row_t stream_q[$];
	out_row_t exp_rows[$];
	logic exp_err[$];
	ilkn_burst_pkg::calendar_t exp_cal[$];
	ilkn_burst_pkg::calendar_t cal_model;

	logic [31:0] lcg_state;
	string test_name;
	logic saw_unlock;

	ilkn_rx_top dut (
		.common_clk     (common_clk),
		.arst_n         (arst_n),
		.lane_words     (lane_words),
		.lane_valid     (lane_valid),
		.locked         (locked),
		.outwords       (outwords),
		.outwords_valid (outwords_valid),
		.calendar       (calendar),
		.burst_err      (burst_err)
	);

	initial begin
		common_clk = 1'b0;
		forever #4 common_clk = ~common_clk;
	end

	////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////
	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string what, input wide_t expected, input wide_t actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
			stop_run();
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// framing word with the control flag set and bit 63 clear
	function automatic ilkn_lane_pkg::lane_word_t fr_word(input logic sync);
		logic [31:0] hi;
		hi = lcg_next();
		return {sync, 1'b1, 1'b0, hi[30:0], lcg_next()};
	endfunction

	// burst control word with a random channel and random low bits
	function automatic ilkn_lane_pkg::lane_word_t bcw_word(input logic sop, input logic eop,
			input ilkn_burst_pkg::calendar_t cal);
		logic [31:0] r;
		r = lcg_next();
		return {2'b01, 1'b1, 1'b0, sop, eop, 4'h0, cal, r[15:8], r};
	endfunction

	function automatic ilkn_lane_pkg::lane_word_t data_word();
		return {2'b00, lcg_next(), lcg_next()};
	endfunction

	// queue a row for sending; kept rows also go on the expected queue and
	// move the calendar to the highest lane burst control word
	task automatic add_row(input ilkn_lane_pkg::lane_word_t w0, input ilkn_lane_pkg::lane_word_t w1,
			input ilkn_lane_pkg::lane_word_t w2, input ilkn_lane_pkg::lane_word_t w3,
			input logic keep, input logic err);
		lane_row_t r;
		out_row_t o;
		r = {w3, w2, w1, w0};
		stream_q.push_back(r);
		if (keep) begin
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				o[i] = r[i][64:0];
				if (r[i][64] && r[i][63]) begin
					cal_model = r[i][55:40];
				end
			end
			exp_rows.push_back(o);
			exp_err.push_back(err);
			exp_cal.push_back(cal_model);
		end
	endtask

	// each lane starts its words after skew idle cycles; a slipped lane
	// gets one extra data word just before row slip_at
	task automatic send_stream(input logic [`ILKN_NUM_LANES-1:0][3:0] skew, input int slip_lane,
			input int slip_at);
		ilkn_lane_pkg::lane_word_t lane_q [`ILKN_NUM_LANES][$];
		int idle [`ILKN_NUM_LANES];
		logic busy;
		for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
			idle[i] = int'(skew[i]);
			for (int k = 0; k < stream_q.size(); k++) begin
				if (i == slip_lane && k == slip_at) begin
					lane_q[i].push_back(data_word());
				end
				lane_q[i].push_back(stream_q[k][i]);
			end
		end
		stream_q.delete();
		busy = 1'b1;
		while (busy) begin
			@(negedge common_clk);
			busy = 1'b0;
			for (int i = 0; i < `ILKN_NUM_LANES; i++) begin
				lane_valid[i] = 1'b0;
				if (idle[i] > 0) begin
					idle[i] = idle[i] - 1;
					busy = 1'b1;
				end else if (lane_q[i].size() > 0) begin
					lane_words[i] = lane_q[i].pop_front();
					lane_valid[i] = 1'b1;
					busy = 1'b1;
				end
			end
		end
	endtask

	// wait until every expected row has come out, then a few quiet cycles
	task automatic drain(input int limit);
		int n;
		n = 0;
		while (exp_rows.size() != 0 && n < limit) begin
			@(posedge common_clk);
			n++;
		end
		if (exp_rows.size() != 0) begin
			$display("ERROR in %s: %0d expected rows never came out", test_name, exp_rows.size());
			stop_run();
		end
		repeat (4) @(negedge common_clk);
	endtask

	////////////////////////////////////////////////////////////////////////
	// output monitor that compares every row with the prediction
	////////////////////////////////////////////////////////////////////////
	always @(negedge common_clk) begin
		if (arst_n) begin
			if (!locked) begin
				saw_unlock = 1'b1;
			end
			if (outwords_valid && exp_rows.size() == 0) begin
				$display("ERROR in %s: an output row came out with none expected", test_name);
				stop_run();
			end else if (outwords_valid) begin
				check("row", wide_t'(exp_rows.pop_front()), wide_t'(outwords));
				check("burst_err", wide_t'(exp_err.pop_front()), wide_t'(burst_err));
				check("calendar", wide_t'(exp_cal.pop_front()), wide_t'(calendar));
			end else begin
				check("burst_err without a row", wide_t'(1'b0), wide_t'(burst_err));
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////
	task automatic reset_values();
		test_name = "reset_values";
		check("locked", wide_t'(1'b0), wide_t'(locked));
		check("outwords_valid", wide_t'(1'b0), wide_t'(outwords_valid));
		check("burst_err", wide_t'(1'b0), wide_t'(burst_err));
		check("calendar", wide_t'(16'hffff), wide_t'(calendar));
	endtask

	task automatic lock_and_order();
		test_name = "lock_and_order";
		// sync row opens the metaframe, then one burst of data rows
		add_row(fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), 1'b0, 1'b0);
		add_row(bcw_word(1'b1, 1'b0, 16'h0f0f), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		repeat (6) add_row(data_word(), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		add_row(data_word(), data_word(), bcw_word(1'b0, 1'b1, 16'h5a5a),
			bcw_word(1'b0, 1'b0, 16'h5a5a), 1'b1, 1'b0);
		// a framing row without a sync marker is stripped too
		add_row(fr_word(1'b0), fr_word(1'b0), fr_word(1'b0), fr_word(1'b0), 1'b0, 1'b0);
		add_row(bcw_word(1'b1, 1'b1, 16'h1e1e), bcw_word(1'b0, 1'b0, 16'h1e1e),
			bcw_word(1'b0, 1'b0, 16'h1e1e), bcw_word(1'b0, 1'b0, 16'h2d2d), 1'b1, 1'b0);
		// lane skews 0, 3, 1 and 5 words
		send_stream({4'd5, 4'd1, 4'd3, 4'd0}, -1, 0);
		drain(200);
		check("locked", wide_t'(1'b1), wide_t'(locked));
	endtask

	task automatic calendar_highest_lane();
		test_name = "calendar_highest_lane";
		add_row(fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), 1'b0, 1'b0);
		add_row(bcw_word(1'b1, 1'b0, 16'h1111), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		// EOP in lane 2 and an idle word in lane 3 with different calendars
		add_row(data_word(), data_word(), bcw_word(1'b0, 1'b1, 16'h2222),
			bcw_word(1'b0, 1'b0, 16'h3333), 1'b1, 1'b0);
		send_stream({4'd2, 4'd0, 4'd1, 4'd0}, -1, 0);
		drain(200);
		check("final calendar", wide_t'(16'h3333), wide_t'(calendar));
	endtask

	task automatic burst_error_flags();
		test_name = "burst_error_flags";
		// data before any SOP
		add_row(data_word(), data_word(), data_word(), data_word(), 1'b1, 1'b1);
		add_row(bcw_word(1'b1, 1'b0, 16'h4444), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		// second SOP while the burst is still open
		add_row(data_word(), bcw_word(1'b1, 1'b0, 16'h4545), data_word(), data_word(), 1'b1, 1'b1);
		add_row(data_word(), data_word(), bcw_word(1'b0, 1'b1, 16'h4646),
			bcw_word(1'b0, 1'b0, 16'h4646), 1'b1, 1'b0);
		// EOP with no burst open
		add_row(bcw_word(1'b0, 1'b1, 16'h4747), bcw_word(1'b0, 1'b0, 16'h4747),
			bcw_word(1'b0, 1'b0, 16'h4747), bcw_word(1'b0, 1'b0, 16'h4747), 1'b1, 1'b1);
		// legal bursts afterwards must stay clean
		add_row(bcw_word(1'b1, 1'b0, 16'h4848), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		add_row(data_word(), data_word(), data_word(), bcw_word(1'b0, 1'b1, 16'h4949), 1'b1, 1'b0);
		add_row(bcw_word(1'b1, 1'b1, 16'h4a4a), bcw_word(1'b0, 1'b0, 16'h4a4a),
			bcw_word(1'b0, 1'b0, 16'h4a4a), bcw_word(1'b0, 1'b0, 16'h4a4a), 1'b1, 1'b0);
		send_stream({4'd0, 4'd2, 4'd0, 4'd1}, -1, 0);
		drain(200);
	endtask

	task automatic relock_after_slip();
		test_name = "relock_after_slip";
		saw_unlock = 1'b0;
		// first metaframe passes while still aligned
		add_row(fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), 1'b0, 1'b0);
		add_row(bcw_word(1'b1, 1'b0, 16'h0a0a), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		add_row(data_word(), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		add_row(data_word(), bcw_word(1'b0, 1'b1, 16'h0b0b), bcw_word(1'b0, 1'b0, 16'h0b0b),
			bcw_word(1'b0, 1'b0, 16'h0b0b), 1'b1, 1'b0);
		// lane 2 slips at this sync row, so this whole metaframe is lost
		add_row(fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), 1'b0, 1'b0);
		repeat (6) add_row(data_word(), data_word(), data_word(), data_word(), 1'b0, 1'b0);
		// the next sync row realigns the lanes
		add_row(fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), fr_word(1'b1), 1'b0, 1'b0);
		add_row(bcw_word(1'b1, 1'b0, 16'h0c0c), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		repeat (3) add_row(data_word(), data_word(), data_word(), data_word(), 1'b1, 1'b0);
		add_row(data_word(), data_word(), data_word(), bcw_word(1'b0, 1'b1, 16'h0d0d), 1'b1, 1'b0);
		send_stream({4'd5, 4'd1, 4'd3, 4'd0}, 2, 4);
		drain(200);
		check("lock lost", wide_t'(1'b1), wide_t'(saw_unlock));
		check("locked again", wide_t'(1'b1), wide_t'(locked));
	endtask

	initial begin
		arst_n = 1'b0;
		lane_words = '0;
		lane_valid = '0;
		lcg_state = 32'ha7af;
		cal_model = '1;
		saw_unlock = 1'b0;
		test_name = "reset";
		repeat (8) @(negedge common_clk);
		arst_n = 1'b1;
		@(negedge common_clk);
		reset_values();
		lock_and_order();
		calendar_highest_lane();
		burst_error_flags();
		relock_after_slip();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: ilkn_rx_top.sv
////////////////////////////////////////////////////////////////////////////
// four lane receive top, deskew feeding the burst parser
// lanes arrive word locked and descrambled on common_clk
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ilkn_rx_params.svh"

module ilkn_rx_top (
	input  logic                                              common_clk,
	input  logic                                              arst_n,
	input  ilkn_lane_pkg::lane_word_t [`ILKN_NUM_LANES-1:0]   lane_words,
	input  logic [`ILKN_NUM_LANES-1:0]                        lane_valid,
	output logic                                              locked,
	output ilkn_burst_pkg::out_word_t [`ILKN_NUM_LANES-1:0]   outwords,
	output logic                                              outwords_valid,
	output ilkn_burst_pkg::calendar_t                         calendar,
	output logic                                              burst_err
);

	// aligned rows between the two stages
	ilkn_row_if row ();

	// align lanes on sync markers and strip framing rows
	ilkn_lane_deskew u_deskew (
		.common_clk (common_clk),
		.arst_n     (arst_n),
		.lane_words (lane_words),
		.lane_valid (lane_valid),
		.row        (row)
	);

	// burst tracking, calendar and error check
	ilkn_burst_parser u_parser (
		.common_clk     (common_clk),
		.arst_n         (arst_n),
		.row            (row),
		.outwords       (outwords),
		.outwords_valid (outwords_valid),
		.calendar       (calendar),
		.burst_err      (burst_err)
	);

	// lock status straight from the deskew FSM
	assign locked = row.locked;

endmodule

`default_nettype wire

// File: src.f
+incdir+.
ilkn_lane_pkg.sv
ilkn_burst_pkg.sv
ilkn_row_if.sv
ilkn_lane_deskew.sv
ilkn_burst_parser.sv
ilkn_rx_top.sv
ilkn_rx_tb.sv
